// ==== Makefile ====
# Verilator simulation of the camera capture testbench

VERILATOR ?= verilator
TOP       ?= tb_cam_capture
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= TEST RESULT: FAIL
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== flist.f ====
src/cam_pkg.sv
src/frame_pkg.sv
src/cam_sync.sv
src/pixel_assembler.sv
src/frame_writer.sv
src/cam_capture_top.sv
sim/cam_capture_asserts.sv
sim/tb_cam_capture.sv

// ==== sim/cam_capture_asserts.sv ====
`timescale 1ns/100ps
`default_nettype none

module cam_capture_asserts (
  input logic                   rst,          // system clock
  input logic                   clk,          // async reset
  input logic                   frame_start,
  input logic                   mem_ready,
  input logic                   mem_valid,
  input frame_pkg::frame_addr_t mem_addr,
  input frame_pkg::pixel_t      mem_data,
  input logic                   overflow
);

  // ------------------------------
  // write port holds until the memory takes it
  hold_until_taken: assert property (@(posedge rst) disable iff (clk)
    mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_data))
    else $error("write port changed before the transfer");

  // sticky until the next frame
  overflow_sticky: assert property (@(posedge rst) disable iff (clk)
    overflow && !frame_start |=> overflow)
    else $error("overflow cleared without a frame start");

endmodule

bind frame_writer cam_capture_asserts u_asserts (
  .rst         (rst),
  .clk         (clk),
  .frame_start (frame_start),
  .mem_ready   (mem_ready),
  .mem_valid   (mem_valid),
  .mem_addr    (mem_addr),
  .mem_data    (mem_data),
  .overflow    (overflow)
);

`default_nettype wire

// ==== sim/tb_cam_capture.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_cam_capture;

  import cam_pkg::*;
  import frame_pkg::*;

  localparam int period     = 20;
  localparam int n_frames   = 10;
  localparam int n_lines    = 4;
  localparam int max_pix    = 9;                                 // longest is the overflow line
  localparam int frame_cyc  = 20 + n_lines * (8 * max_pix + 40); // 8 clocks per pixel
  localparam int timeout_ns = (5 + n_frames * frame_cyc + 1000) * period;
  localparam logic [31:0] seed = 32'd71285;

  logic        rst;         // clock
  logic        clk;         // reset
  logic        pclk;
  logic        href;
  logic        vsync;
  logic [7:0]  data;
  cam_mode_t   mode;
  logic        mem_ready;
  logic        mem_valid;
  frame_addr_t mem_addr;
  pixel_t      mem_data;
  logic        overflow;

  frame_addr_t exp_addr_q [$];         // model output in write order
  pixel_t      exp_data_q [$];
  logic [31:0] stim_st;                // lfsr for camera side
  logic [31:0] ready_st;               // separate lfsr for mem_ready
  int          ready_mode;             // 0 high, 1 random, 2 held low
  cam_mode_t   frame_mode;             // mode the dut latched
  cam_mode_t   modes [n_frames+1];
  string       test_name;

  always #(period/2) rst = ~rst;

  cam_capture_top uut (
    .rst (rst), .clk (clk), .pclk (pclk), .href (href), .vsync (vsync), .data (data),
    .mode (mode), .mem_ready (mem_ready), .mem_valid (mem_valid),
    .mem_addr (mem_addr), .mem_data (mem_data), .overflow (overflow)
  );

  // ------------------------------
  // galois lfsr for x^32+x^22+x^2+x+1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic lsb;
    lsb = s[0];
    s = s >> 1;
    if (lsb) s = s ^ 32'h8020_0003;
    return s;
  endfunction

  task automatic draw(inout logic [31:0] st, input int n, output logic [7:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      st = lfsr_next(st);
      v = {v[6:0], st[0]};  // one step per bit
    end
  endtask

  // expected pixel from the byte layout of each format
  function automatic pixel_t ref_pixel(input cam_mode_t m, input cam_word_u w);
    logic [7:0] f;
    logic [7:0] s;
    pixel_t     p;
    f = w.yuv.first_y;
    s = w.yuv.second_y;
    case (m)
      mode_rgb444:    p = {f[3:1], s[7:5], s[3:2]};
      mode_rgb555:    p = {f[6:4], f[1:0], s[7], s[4:3]};
      mode_rgb565:    p = {f[7:5], f[2:0], s[4:3]};
      mode_yuv_first: p = f;
      default:        p = s;  // 4..7 carry luma in second byte
    endcase
    return p;
  endfunction

  // ------------------------------
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_addr(input string what, input frame_addr_t expected,
                            input frame_addr_t actual);
    if (expected !== actual)
      fail_run($sformatf("mismatch %s %s: expected %0d, actual %0d",
                         test_name, what, expected, actual));
  endtask

  task automatic check_pixel(input string what, input pixel_t expected, input pixel_t actual);
    if (expected !== actual)
      fail_run($sformatf("mismatch %s %s: expected %02h, actual %02h",
                         test_name, what, expected, actual));
  endtask

  task automatic check_bit(input string what, input logic expected, input logic actual);
    if (expected !== actual)
      fail_run($sformatf("mismatch %s %s: expected %b, actual %b",
                         test_name, what, expected, actual));
  endtask

  // ------------------------------
  // camera bus model with pclk low 2 clocks then high 2
  task automatic idle(input int n);
    repeat (n) @(negedge rst);
  endtask

  task automatic drive_byte(input logic [7:0] b);
    @(negedge rst);
    pclk = 1'b0;  // fall closes the previous byte
    href = 1'b1;
    data = b;
    @(negedge rst);
    @(negedge rst);
    pclk = 1'b1;
    @(negedge rst);
  endtask

  task automatic vsync_pulse(input int len);
    @(negedge rst);
    vsync = 1'b1;
    repeat (len) @(negedge rst);
    vsync = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_addr_q.size() != 0) @(negedge rst);
  endtask

  // keep counts the leading pixels that survive the fifo
  task automatic send_line(input int line, input int npix, input int keep);
    logic [7:0] b0;
    logic [7:0] b1;
    cam_word_u  w;
    for (int p = 0; p < npix; p++) begin
      draw(stim_st, 8, b0);
      draw(stim_st, 8, b1);
      w = {b0, b1};
      if (p < keep) begin
        exp_addr_q.push_back(frame_addr_t'(line * img_cols + p));  // fixed stride
        exp_data_q.push_back(ref_pixel(frame_mode, w));
      end
      drive_byte(b0);
      drive_byte(b1);
    end
    @(negedge rst);
    pclk = 1'b0;  // last fall together with href drop
    href = 1'b0;
  endtask

  task automatic send_frame(input int f);
    logic [7:0] r;
    int         npix;
    int         keep;
    logic       ovf;
    logic       glitch;
    ovf        = (f == 6);      // one frame with a starved line
    glitch     = (f % 3 == 1);
    test_name  = $sformatf("frame %0d mode %0d", f, modes[f]);
    frame_mode = modes[f];
    ready_mode <= (f >= 4) ? 1 : 0;
    vsync_pulse(6);
    idle(10);
    check_bit("overflow at frame start", 1'b0, overflow);
    for (int l = 0; l < n_lines; l++) begin
      if (l == 1) mode = modes[f+1];  // mid-frame change waits for next frame
      if (glitch && l == 2) begin
        draw(stim_st, 2, r);
        vsync_pulse(1 + int'(r) % 3);  // short spurious pulse
        idle(6);
      end
      draw(stim_st, 3, r);
      npix = 1 + int'(r);
      keep = npix;
      if (ovf && l == 1) begin
        wait_drain();
        ready_mode <= 2;
        npix = fifo_depth + 2 + int'(r[1:0]);
        keep = fifo_depth;  // rest dropped
      end
      send_line(l, npix, keep);
      idle(8);
      if (ovf && l == 1) begin
        idle(8);
        check_bit("overflow after dropped pixels", 1'b1, overflow);
        ready_mode <= (f >= 4) ? 1 : 0;
      end
    end
    wait_drain();
    check_bit("overflow at frame end", ovf, overflow);
  endtask

  // ------------------------------
  // ready driver and write checker
  always @(negedge rst) begin
    logic [7:0] r;
    if (!clk) begin
      case (ready_mode)
        0: mem_ready = 1'b1;
        1: begin
          draw(ready_st, 2, r);
          mem_ready = |r[1:0];  // ~75% duty
        end
        default: mem_ready = 1'b0;
      endcase
      if (mem_valid && mem_ready) begin  // transfer on next posedge
        if (exp_addr_q.size() == 0) begin
          fail_run("memory write seen with no pixel pending");
        end else begin
          check_addr("write address", exp_addr_q.pop_front(), mem_addr);
          check_pixel("write data", exp_data_q.pop_front(), mem_data);
        end
      end
    end
  end

  initial begin
    #(timeout_ns);
    fail_run("watchdog expired, capture did not finish in time");
  end

  initial begin
    logic [7:0] r;
    rst = 1'b0;
    clk = 1'b1;
    pclk = 1'b0;
    href = 1'b0;
    vsync = 1'b0;
    data = '0;
    mode = '0;
    mem_ready = 1'b0;
    stim_st = seed;
    ready_st = seed;
    ready_mode = 0;
    frame_mode = '0;
    test_name = "reset";
    for (int f = 0; f <= n_frames; f++) begin
      if (f < 8) begin
        modes[f] = cam_mode_t'(f);  // every mode once
      end else begin
        draw(stim_st, 3, r);
        modes[f] = r[2:0];  // then random
      end
    end
    mode = modes[0];
    repeat (5) @(posedge rst);
    @(negedge rst);
    clk = 1'b0;
    idle(4);
    check_bit("overflow after reset", 1'b0, overflow);
    check_bit("mem_valid after reset", 1'b0, mem_valid);
    for (int f = 0; f < n_frames; f++) send_frame(f);
    idle(20);
    check_bit("mem_valid after last frame", 1'b0, mem_valid);  // nothing left queued
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/cam_capture_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module cam_capture_top (
  input  logic                   rst,        // system clock
  input  logic                   clk,        // async reset, active high
  input  logic                   pclk,
  input  logic                   href,
  input  logic                   vsync,
  input  logic [7:0]             data,
  input  cam_pkg::cam_mode_t     mode,
  input  logic                   mem_ready,
  output logic                   mem_valid,
  output frame_pkg::frame_addr_t mem_addr,
  output frame_pkg::pixel_t      mem_data,
  output logic                   overflow
);

  import frame_pkg::*;

  logic       byte_strobe;
  logic [7:0] byte_data;
  logic       frame_start;
  logic       line_end;
  logic       line_idle;
  logic       pix_valid;
  pixel_t     pix_data;

  // ------------------------------
  cam_sync u_sync (
    .rst         (rst),
    .clk         (clk),
    .pclk        (pclk),
    .href        (href),
    .vsync       (vsync),
    .data        (data),
    .byte_strobe (byte_strobe),
    .byte_data   (byte_data),
    .frame_start (frame_start),
    .line_end    (line_end),
    .line_idle   (line_idle)
  );

  pixel_assembler u_asm (
    .rst         (rst),
    .clk         (clk),
    .mode        (mode),
    .byte_strobe (byte_strobe),
    .byte_data   (byte_data),
    .frame_start (frame_start),
    .line_idle   (line_idle),
    .pix_valid   (pix_valid),
    .pix_data    (pix_data)
  );

  frame_writer u_writer (
    .rst         (rst),
    .clk         (clk),
    .pix_valid   (pix_valid),
    .pix_data    (pix_data),
    .frame_start (frame_start),
    .line_end    (line_end),
    .mem_ready   (mem_ready),
    .mem_valid   (mem_valid),
    .mem_addr    (mem_addr),
    .mem_data    (mem_data),
    .overflow    (overflow)
  );

endmodule

`default_nettype wire

// ==== src/cam_pkg.sv ====
`default_nettype none

package cam_pkg;

  localparam int sync_stages = 3;  // flops between camera pins and logic

  // format mode, picked by switches on the board
  typedef logic [2:0] cam_mode_t;

  localparam cam_mode_t mode_rgb444     = 3'd0;
  localparam cam_mode_t mode_rgb555     = 3'd1;
  localparam cam_mode_t mode_rgb565     = 3'd2;
  localparam cam_mode_t mode_yuv_first  = 3'd3;  // luma in first byte
  localparam cam_mode_t mode_yuv_second = 3'd4;  // this value and above

  // ------------------------------
  // two-byte pixel word, first byte in [15:8]
  typedef union packed {
    struct packed {
      logic [3:0] pad_a;
      logic [2:0] red;     // first 3:1
      logic       pad_b;
      logic [2:0] green;   // second 7:5
      logic       pad_c;
      logic [1:0] blue;    // second 3:2
      logic [1:0] pad_d;
    } rgb444;
    struct packed {
      logic       pad_a;
      logic [2:0] red;       // first 6:4
      logic [1:0] pad_b;
      logic [1:0] green_hi;  // first 1:0
      logic       green_lo;  // second 7
      logic [1:0] pad_c;
      logic [1:0] blue;      // second 4:3
      logic [2:0] pad_d;
    } rgb555;
    struct packed {
      logic [2:0] red;     // first 7:5
      logic [1:0] pad_a;
      logic [2:0] green;   // first 2:0, top of green only
      logic [2:0] pad_b;
      logic [1:0] blue;    // second 4:3
      logic [2:0] pad_c;
    } rgb565;
    struct packed {
      logic [7:0] first_y;
      logic [7:0] second_y;
    } yuv;
  } cam_word_u;

endpackage

`default_nettype wire

// ==== src/cam_sync.sv ====
`timescale 1ns/100ps
`default_nettype none

module cam_sync (
  input  logic       rst,          // system clock
  input  logic       clk,          // async reset, active high
  input  logic       pclk,         // camera byte clock
  input  logic       href,
  input  logic       vsync,
  input  logic [7:0] data,
  output logic       byte_strobe,
  output logic [7:0] byte_data,
  output logic       frame_start,
  output logic       line_end,
  output logic       line_idle
);

  import cam_pkg::*;

  localparam int last = sync_stages - 1;

  logic [sync_stages-1:0] pclk_sr;     // bit 0 is the newest sample
  logic [sync_stages-1:0] href_sr;
  logic [sync_stages-1:0] vsync_sr;
  logic [7:0]             data_sr [sync_stages];
  logic [3:0]             vsync_hist;  // synced vsync, older samples
  logic                   href_last;   // delayed href, one more cycle
  logic                   pclk_fall;
  logic                   vsync_up4;

  // ------------------------------
  // synchronizer chains
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      pclk_sr  <= '0;
      href_sr  <= '0;
      vsync_sr <= '0;
    end else begin
      pclk_sr  <= {pclk_sr[last-1:0], pclk};
      href_sr  <= {href_sr[last-1:0], href};
      vsync_sr <= {vsync_sr[last-1:0], vsync};
    end
  end

  always_ff @(posedge rst) begin
    data_sr[0] <= data;
    for (int i = 1; i < sync_stages; i++) begin
      data_sr[i] <= data_sr[i-1];
    end
  end

  assign pclk_fall = pclk_sr[last] & ~pclk_sr[last-1];  // high then low

  // vsync glitches last up to a few clocks, want four highs in a row
  assign vsync_up4 = (&vsync_hist[2:0]) & vsync_sr[last] & ~vsync_hist[3];

  // ------------------------------
  // strobes, all registered so they line up
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      vsync_hist  <= '0;
      href_last   <= 1'b0;
      byte_strobe <= 1'b0;
      frame_start <= 1'b0;
      line_end    <= 1'b0;
      line_idle   <= 1'b1;  // no line until href shows up
    end else begin
      vsync_hist  <= {vsync_hist[2:0], vsync_sr[last]};
      href_last   <= href_sr[last];
      byte_strobe <= pclk_fall & href_sr[last];  // bytes only inside a line
      frame_start <= vsync_up4;
      line_end    <= href_last & ~href_sr[last];  // never ahead of last pixel
      line_idle   <= ~href_sr[last];
    end
  end

  // byte sampled while pclk was still high
  always_ff @(posedge rst) begin
    if (pclk_fall) begin
      byte_data <= data_sr[last];
    end
  end

endmodule

`default_nettype wire

// ==== src/frame_pkg.sv ====
`default_nettype none

package frame_pkg;

  // ------------------------------
  // image geometry
  localparam int img_cols = 640;  // pixels per line
  localparam int img_rows = 480;  // lines per frame

  // 640*480 = 307200, fits in 19 bits
  localparam int addr_w = 19;

  typedef logic [addr_w-1:0] frame_addr_t;

  // rgb332 or 8 bit gray
  typedef logic [7:0] pixel_t;

  // ------------------------------
  // write side buffering
  localparam int fifo_depth = 4;  // keep a power of two

endpackage

`default_nettype wire

// ==== src/frame_writer.sv ====
`timescale 1ns/100ps
`default_nettype none

module frame_writer (
  input  logic                   rst,        // system clock
  input  logic                   clk,        // async reset, active high
  input  logic                   pix_valid,
  input  frame_pkg::pixel_t      pix_data,
  input  logic                   frame_start,
  input  logic                   line_end,
  input  logic                   mem_ready,
  output logic                   mem_valid,
  output frame_pkg::frame_addr_t mem_addr,
  output frame_pkg::pixel_t      mem_data,
  output logic                   overflow    // sticky, per frame
);

  import frame_pkg::*;

  localparam int ptr_w = $clog2(fifo_depth);

  frame_addr_t    line_base;  // pixels in all previous lines
  frame_addr_t    line_pos;   // pixel count in this line
  frame_addr_t    pix_addr;
  frame_addr_t    addr_mem [fifo_depth];
  pixel_t         data_mem [fifo_depth];
  logic [ptr_w:0] wr_ptr;     // extra bit tells full from empty
  logic [ptr_w:0] rd_ptr;
  logic           full;
  logic           push;
  logic           pop;

  assign pix_addr = line_base + line_pos;

  assign full = (wr_ptr[ptr_w] != rd_ptr[ptr_w]) &&
                (wr_ptr[ptr_w-1:0] == rd_ptr[ptr_w-1:0]);
  assign push = pix_valid & ~full;     // camera can't wait, drop on full
  assign pop  = mem_valid & mem_ready;

  // ------------------------------
  // addressing, fifo pointers, overflow
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      line_base <= '0;
      line_pos  <= '0;
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      overflow  <= 1'b0;
    end else begin
      if (frame_start) begin
        line_base <= '0;
        line_pos  <= '0;
      end else if (line_end) begin
        // fixed stride, odd line lengths don't shift the next line
        line_base <= line_base + frame_addr_t'(img_cols);
        line_pos  <= '0;
      end else if (pix_valid) begin
        line_pos <= line_pos + 1'b1;
      end
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      if (frame_start) overflow <= 1'b0;
      else if (pix_valid && full) overflow <= 1'b1;
    end
  end

  always_ff @(posedge rst) begin
    if (push) begin
      addr_mem[wr_ptr[ptr_w-1:0]] <= pix_addr;
      data_mem[wr_ptr[ptr_w-1:0]] <= pix_data;
    end
  end

  // head of the fifo straight onto the port
  assign mem_valid = (wr_ptr != rd_ptr);
  assign mem_addr  = addr_mem[rd_ptr[ptr_w-1:0]];
  assign mem_data  = data_mem[rd_ptr[ptr_w-1:0]];

endmodule

`default_nettype wire

// ==== src/pixel_assembler.sv ====
`timescale 1ns/100ps
`default_nettype none

module pixel_assembler (
  input  logic               rst,          // system clock
  input  logic               clk,          // async reset, active high
  input  cam_pkg::cam_mode_t mode,         // format switches
  input  logic               byte_strobe,
  input  logic [7:0]         byte_data,
  input  logic               frame_start,
  input  logic               line_idle,
  output logic               pix_valid,
  output frame_pkg::pixel_t  pix_data
);

  import cam_pkg::*;
  import frame_pkg::*;

  cam_mode_t  mode_q;    // mode of the running frame
  logic       second;    // next byte closes a pixel
  logic [7:0] first_q;   // held first byte
  cam_word_u  word;
  pixel_t     pix_dec;

  // ------------------------------
  // decode through the union views
  function automatic pixel_t decode(cam_mode_t m, cam_word_u w);
    pixel_t p;
    case (m)
      mode_rgb444: begin
        p = {w.rgb444.red, w.rgb444.green, w.rgb444.blue};
      end
      mode_rgb555: begin
        p = {w.rgb555.red, w.rgb555.green_hi, w.rgb555.green_lo,
             w.rgb555.blue};
      end
      mode_rgb565: begin
        p = {w.rgb565.red, w.rgb565.green, w.rgb565.blue};
      end
      mode_yuv_first: begin
        p = w.yuv.first_y;
      end
      default: begin
        p = w.yuv.second_y;  // modes 4..7 all take the second byte
      end
    endcase
    return p;
  endfunction

  assign word    = {first_q, byte_data};  // first byte on top
  assign pix_dec = decode(mode_q, word);

  // ------------------------------
  // byte phase and mode latch
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      mode_q    <= mode_rgb444;
      second    <= 1'b0;
      pix_valid <= 1'b0;
    end else begin
      pix_valid <= 1'b0;
      if (frame_start) begin
        mode_q <= mode;  // switch changes wait for a new frame
        second <= 1'b0;
      end else if (byte_strobe) begin
        second    <= ~second;
        pix_valid <= second;  // pulse after the closing byte
      end else if (line_idle) begin
        second <= 1'b0;  // realign at every line
      end
    end
  end

  // payload registers
  always_ff @(posedge rst) begin
    if (byte_strobe && !second) begin
      first_q <= byte_data;
    end
    if (byte_strobe && second) begin
      pix_data <= pix_dec;
    end
  end

endmodule

`default_nettype wire
